/* Bender.yml */
package:
  name: mips_backend

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mips_except_pkg.sv
      - verilog/mips_pipe_pkg.sv
      - verilog/mult_timer.sv
      - verilog/ex_stage.sv
      - verilog/ex_mem.sv
      - verilog/mem_stage.sv
      - verilog/pipe_ctrl.sv
      - verilog/mips_backend.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/mips_backend_sva.sv
      - verif/mips_backend_tb.sv

/* mips_backend.f */
+incdir+verilog
verilog/mips_except_pkg.sv
verilog/mips_pipe_pkg.sv
verilog/mult_timer.sv
verilog/ex_stage.sv
verilog/ex_mem.sv
verilog/mem_stage.sv
verilog/pipe_ctrl.sv
verilog/mips_backend.sv
verif/mips_backend_sva.sv
verif/mips_backend_tb.sv

/* verif/mips_backend_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_backend_sva import mips_pipe_pkg::*; (
  input wire          clk,
  input wire          reset,
  input wire          issue_ready,
  input wire          flush,
  input wire          except_valid,
  input wire          timer_done,
  input wire [1:0]    ctrl_state,
  input wire ex_mem_t mem_in
);

  localparam logic [1:0] MULT_WAIT_ST = 2'd1;
  localparam logic [1:0] HALT_ST = 2'd2;

  int unsigned fail_count = 0;

  // ========================================
  // Handshake
  // ========================================

  // The last MULT_WAIT cycle is the one where the MULT itself is taken.
  property ready_low_when_busy;
    @(posedge clk) disable iff (reset)
      ((ctrl_state == MULT_WAIT_ST && !timer_done) || ctrl_state == HALT_ST) |-> !issue_ready;
  endproperty

  ready_low_a: assert property (ready_low_when_busy)
    else begin
      $error("issue_ready is high while the pipe waits on the multiplier or is halted");
      fail_count++;
    end

  // ========================================
  // Flush and exceptions
  // ========================================

  property flush_gives_bubble;
    @(posedge clk) disable iff (reset)
      flush |=> (mem_in == '0);
  endproperty

  flush_bubble_a: assert property (flush_gives_bubble)
    else begin
      $error("EX/MEM does not hold a NOP bubble after a flush");
      fail_count++;
    end

  property except_one_cycle;
    @(posedge clk) disable iff (reset)
      except_valid |=> !except_valid;
  endproperty

  except_pulse_a: assert property (except_one_cycle)
    else begin
      $error("except_valid stays high for more than one cycle");
      fail_count++;
    end

endmodule

`default_nettype wire

/* verif/mips_backend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_backend_tb
  import mips_pipe_pkg::*;
  import mips_except_pkg::*;
();

  localparam int DW = `MIPS_DATA_W;
  localparam int RESET_CYCLES = 10;
  localparam int TIMEOUT = 60;

  typedef struct packed {
    wb_t         wb;
    logic [63:0] at;
  } exp_wb_t;

  typedef struct packed {
    except_t     info;
    logic [63:0] at;
  } exp_exc_t;

  logic clk;
  logic reset;
  logic issue_valid;
  issue_t issue;
  logic issue_ready;
  logic resume;
  logic wb_valid;
  wb_t wb;
  logic except_valid;
  except_t except_info;

  exp_wb_t wb_q [$];
  exp_exc_t exc_q [$];
  exp_wb_t wb_exp;
  exp_exc_t exc_exp;
  logic [DW-1:0] model_mem [`MIPS_MEM_WORDS];
  logic [DW-1:0] model_hi;
  logic [DW-1:0] model_lo;
  logic [63:0] lcg_state = 64'd64107;
  logic [DW-1:0] next_pc = 32'h0040_0000;
  string test_name = "reset";
  int errors = 0;
  int errors_at_start = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int exc_seen = 0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  mips_backend dut0 (
    .clk(clk), .reset(reset), .issue_valid(issue_valid), .issue(issue),
    .issue_ready(issue_ready), .resume(resume), .wb_valid(wb_valid), .wb(wb),
    .except_valid(except_valid), .except_info(except_info)
  );

  bind mips_backend mips_backend_sva sva0 (
    .clk(clk), .reset(reset), .issue_ready(issue_ready), .flush(flush),
    .except_valid(except_valid), .timer_done(timer_done),
    .ctrl_state(pipe_ctrl0.state_q), .mem_in(mem_in)
  );

  // ========================================
  // Stimulus helpers
  // ========================================

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state[63:32];
  endfunction

  function issue_t make_issue(input alu_op_e op, input logic [DW-1:0] rs,
                              input logic [DW-1:0] rt, input logic [DW-1:0] imm);
    issue_t ins;
    logic [31:0] r;
    r = lcg_next();
    ins.op = op;
    ins.pc = next_pc;
    ins.rs_val = rs;
    ins.rt_val = rt;
    ins.imm = imm;
    ins.wd = r[`MIPS_REG_AW-1:0];
    next_pc = next_pc + 4;
    return ins;
  endfunction

  // Splits the address into a base and a 16-bit offset, as a compiler would.
  function issue_t make_mem(input alu_op_e op, input logic [DW-1:0] addr,
                            input logic [DW-1:0] data);
    logic [31:0] r;
    logic [DW-1:0] imm;
    r = lcg_next();
    imm = {{16{r[15]}}, r[15:0]};
    return make_issue(op, addr - imm, data, imm);
  endfunction

  task automatic log_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic report_mismatch(input string what, input logic [95:0] expected,
                                 input logic [95:0] actual);
    errors++;
    $display("Error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
  endtask

  // ========================================
  // Reference model
  // ========================================

  task automatic model_accept(input issue_t ins, input logic [63:0] t_acc);
    exp_wb_t w;
    exp_exc_t x;
    longint a;
    longint b;
    longint wide;
    logic [DW-1:0] addr;
    int idx;
    logic writes;
    a = $signed(ins.rs_val);
    b = $signed(ins.rt_val);
    addr = ins.rs_val + ins.imm;
    idx = (addr >> 2) % `MIPS_MEM_WORDS;
    writes = 1'b1;
    w.wb.wd = ins.wd;
    w.wb.wdata = '0;
    w.at = t_acc + 150; // Writeback is seen in the cycle after the second edge.
    x.info = '0;
    x.info.code = NONE;
    x.info.pc = ins.pc;
    x.at = t_acc + 50;
    case (ins.op)
      ADD, SUB: begin
        wide = (ins.op == ADD) ? a + b : a - b;
        w.wb.wdata = wide[31:0];
        if (wide[32] != wide[31]) x.info.code = OVERFLOW; // Result needs 33 bits.
      end
      AND: w.wb.wdata = ins.rs_val & ins.rt_val;
      OR: w.wb.wdata = ins.rs_val | ins.rt_val;
      XOR: w.wb.wdata = ins.rs_val ^ ins.rt_val;
      SLT: w.wb.wdata = (a < b) ? 32'd1 : 32'd0;
      LW: begin
        if (addr[1:0] != 2'b00) begin
          x.info.code = ADDR_LOAD;
          x.info.bad_addr = addr;
        end else begin
          w.wb.wdata = model_mem[idx];
        end
      end
      SW: begin
        writes = 1'b0;
        if (addr[1:0] != 2'b00) begin
          x.info.code = ADDR_STORE;
          x.info.bad_addr = addr;
        end else begin
          model_mem[idx] = ins.rt_val;
        end
      end
      MULT: begin
        writes = 1'b0;
        wide = a * b;
        model_hi = wide[63:32];
        model_lo = wide[31:0];
      end
      MFHI: w.wb.wdata = model_hi;
      MFLO: w.wb.wdata = model_lo;
      default: writes = 1'b0;
    endcase
    if (x.info.code != NONE) begin
      exc_q.push_back(x);
    end else if (writes) begin
      wb_q.push_back(w);
    end
  endtask

  // ========================================
  // Handshake and sequencing
  // ========================================

  task automatic issue_one(input issue_t ins, output int stalls);
    stalls = 0;
    issue_valid = 1'b1;
    issue = ins;
    @(negedge clk);
    while (issue_ready !== 1'b1) begin
      stalls++;
      if (stalls > TIMEOUT) begin
        $display("Timeout in %s: %s at pc %h was never accepted", test_name, ins.op.name(),
                 ins.pc);
        $display("SIMULATION FAILED");
        $finish;
      end
      @(negedge clk);
    end
    @(posedge clk);
    model_accept(ins, $time);
    #5;
    issue_valid = 1'b0;
  endtask

  task automatic hold_check(input issue_t ins, input int cycles);
    issue_valid = 1'b1;
    issue = ins;
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      if (issue_ready !== 1'b0) begin
        log_failure($sformatf("Test %s: issue accepted while halted after a fault", test_name));
      end
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (wb_q.size() != 0 || exc_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timeout in %s: %0d writebacks and %0d exceptions never arrived", test_name,
                 wb_q.size(), exc_q.size());
        $display("SIMULATION FAILED");
        $finish;
      end
    end
    repeat (3) @(posedge clk); // Room for a stray late writeback to show up.
    #5;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("Test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  // Checks every writeback and exception report against the model, in order.
  always @(negedge clk) begin
    if (!reset) begin
      if ($isunknown({issue_ready, wb_valid, except_valid})) begin
        log_failure($sformatf("Test %s: a control output is unknown", test_name));
      end
      if (wb_valid === 1'b1) begin
        if (wb_q.size() == 0) begin
          log_failure($sformatf("Test %s: writeback to r%0d with none expected", test_name,
                                wb.wd));
        end else begin
          wb_exp = wb_q.pop_front();
          if ($time != wb_exp.at) begin
            report_mismatch("writeback time", wb_exp.at, $time);
          end
          if (wb !== wb_exp.wb) begin
            report_mismatch("writeback", wb_exp.wb, wb);
          end
        end
      end
      if (except_valid === 1'b1) begin
        exc_seen++;
        if (exc_q.size() == 0) begin
          log_failure($sformatf("Test %s: exception at pc %h with none expected", test_name,
                                except_info.pc));
        end else begin
          exc_exp = exc_q.pop_front();
          if ($time != exc_exp.at) begin
            report_mismatch("exception time", exc_exp.at, $time);
          end
          if (except_info !== exc_exp.info) begin
            report_mismatch("exception", exc_exp.info, except_info);
          end
        end
      end
    end
  end

  // ========================================
  // Tests
  // ========================================

  initial begin
    issue_t ins;
    issue_t young;
    int stalls;
    int i;
    int k;
    int exc_before;
    logic [DW-1:0] a;
    logic [DW-1:0] b;
    logic [DW-1:0] addr;
    logic [DW-1:0] data;
    reset = 1'b1;
    issue_valid = 1'b0;
    issue = '0;
    resume = 1'b0;
    model_hi = '0;
    model_lo = '0;
    for (i = 0; i < `MIPS_MEM_WORDS; i++) begin
      model_mem[i] = '0;
    end

    begin_test("reset");
    for (i = 0; i < RESET_CYCLES - 1; i++) begin
      @(negedge clk);
      if ({issue_ready, wb_valid, except_valid} !== 3'b000) begin
        report_mismatch("outputs in reset", 3'b000, {issue_ready, wb_valid, except_valid});
      end
    end
    @(posedge clk);
    #5;
    reset = 1'b0;
    @(negedge clk);
    if ({issue_ready, wb_valid, except_valid} !== 3'b000) begin
      report_mismatch("outputs after reset", 3'b000, {issue_ready, wb_valid, except_valid});
    end
    @(posedge clk);
    #5;
    end_test();

    begin_test("alu");
    for (k = 0; k < 24; k++) begin
      a = lcg_next();
      b = lcg_next();
      ins = make_issue(alu_op_e'(ADD + lcg_next() % 6), {a[31], a[31:1]}, {b[31], b[31:1]},
                       lcg_next());
      issue_one(ins, stalls);
      if (stalls != 0) begin
        report_mismatch("stall cycles", 0, stalls);
      end
    end
    drain();
    end_test();

    begin_test("memory");
    for (k = 0; k < 4; k++) begin
      addr = lcg_next() & ~32'h3;
      issue_one(make_mem(LW, addr, '0), stalls); // Untouched words still hold zero.
    end
    for (k = 0; k < 12; k++) begin
      addr = lcg_next() & ~32'h3;
      data = lcg_next();
      issue_one(make_mem(SW, addr, data), stalls);
      issue_one(make_mem(LW, addr, '0), stalls);
      addr = lcg_next() & ~32'h3;
      issue_one(make_mem(LW, addr, '0), stalls);
    end
    drain();
    end_test();

    begin_test("mult");
    for (k = 0; k < 6; k++) begin
      a = lcg_next();
      b = lcg_next();
      issue_one(make_issue(MULT, a, b, '0), stalls);
      if (stalls != `MIPS_MULT_CYCLES) begin
        report_mismatch("stall cycles", `MIPS_MULT_CYCLES, stalls);
      end
      if (k == 5) begin
        a = lcg_next();
        issue_one(make_issue(MULT, b, a, '0), stalls);
      end
      if (k % 2 == 1) begin
        issue_one(make_issue(MFLO, '0, '0, '0), stalls);
        issue_one(make_issue(MFHI, '0, '0, '0), stalls);
      end else begin
        issue_one(make_issue(MFHI, '0, '0, '0), stalls);
        issue_one(make_issue(MFLO, '0, '0, '0), stalls);
      end
    end
    drain();
    end_test();

    begin_test("except");
    for (k = 0; k < 3; k++) begin
      addr = lcg_next() & ~32'h3;
      data = lcg_next();
      issue_one(make_mem(SW, addr, data), stalls);
      a = lcg_next();
      b = lcg_next();
      case (k)
        0: ins = make_issue(ADD, {2'b01, a[29:0]}, {2'b01, b[29:0]}, '0);
        1: ins = make_mem(LW, addr | (1 + a % 3), '0);
        default: ins = make_mem(SW, addr | (1 + a % 3), ~data);
      endcase
      young = make_mem(LW, addr, '0); // Reads back the word the fault must not touch.
      exc_before = exc_seen;
      issue_one(ins, stalls);
      hold_check(young, 6);
      @(posedge clk);
      #5;
      resume = 1'b1;
      @(posedge clk);
      #5;
      resume = 1'b0;
      if (exc_seen != exc_before + 1) begin
        report_mismatch("exception count", exc_before + 1, exc_seen);
      end
      issue_one(young, stalls);
    end
    drain();
    end_test();

    errors = errors + dut0.sva0.fail_count;
    $display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures", tests_run,
             tests_failed, errors, dut0.sva0.fail_count);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/ex_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mem import mips_pipe_pkg::*; import mips_except_pkg::*; (
  input  wire          clk,
  input  wire          reset,
  input  wire          en,
  input  wire          flush,
  input  wire ex_mem_t ex_in,
  output ex_mem_t      mem_in
);

  // ========================================
  // Pipeline register
  // ========================================

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      mem_in <= '0; // All zero decodes as a NOP bubble that writes nothing.
    end else if (en) begin
      mem_in <= ex_in;
    end
  end

endmodule

`default_nettype wire

/* verilog/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module ex_stage import mips_pipe_pkg::*; import mips_except_pkg::*; (
  input  wire         clk,
  input  wire         reset,
  input  wire issue_t issue,
  input  wire         mult_start,
  input  wire hilo_t  hilo,
  input  wire ex_mem_t fwd,
  output ex_mem_t     ex_out,
  output logic        is_multi
);

  localparam int DW = `MIPS_DATA_W;

  logic signed [2*DW-1:0] prod_q;
  logic [DW-1:0] sum;
  logic [DW-1:0] diff;
  logic [DW-1:0] addr;
  logic [DW-1:0] hi_src;
  logic [DW-1:0] lo_src;
  logic add_ovf;
  logic sub_ovf;
  logic slt;

  assign sum = issue.rs_val + issue.rt_val;
  assign diff = issue.rs_val - issue.rt_val;
  assign addr = issue.rs_val + issue.imm;
  assign add_ovf = (issue.rs_val[DW-1] == issue.rt_val[DW-1]) && (sum[DW-1] != issue.rs_val[DW-1]);
  assign sub_ovf = (issue.rs_val[DW-1] != issue.rt_val[DW-1]) && (diff[DW-1] != issue.rs_val[DW-1]);
  assign slt = $signed(issue.rs_val) < $signed(issue.rt_val);
  assign is_multi = (issue.op == MULT);

  // A HI/LO write still sitting in EX/MEM is newer than the registered copy.
  assign hi_src = fwd.whilo ? fwd.hi : hilo.hi;
  assign lo_src = fwd.whilo ? fwd.lo : hilo.lo;

  // Operands stay stable while issue is held, so the product settles long before it is used.
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_q <= '0;
    end else if (mult_start) begin
      prod_q <= $signed(issue.rs_val) * $signed(issue.rt_val);
    end
  end

  always_comb begin
    ex_out = '0;
    ex_out.aluop = issue.op;
    ex_out.except = NONE;
    ex_out.wd = issue.wd;
    ex_out.pc = issue.pc;
    ex_out.reg2 = issue.rt_val;
    case (issue.op)
      ADD: begin
        ex_out.wreg = 1'b1;
        ex_out.wdata = sum;
        if (add_ovf) ex_out.except = OVERFLOW;
      end
      SUB: begin
        ex_out.wreg = 1'b1;
        ex_out.wdata = diff;
        if (sub_ovf) ex_out.except = OVERFLOW;
      end
      AND: begin
        ex_out.wreg = 1'b1;
        ex_out.wdata = issue.rs_val & issue.rt_val;
      end
      OR: begin
        ex_out.wreg = 1'b1;
        ex_out.wdata = issue.rs_val | issue.rt_val;
      end
      XOR: begin
        ex_out.wreg = 1'b1;
        ex_out.wdata = issue.rs_val ^ issue.rt_val;
      end
      SLT: begin
        ex_out.wreg = 1'b1;
        ex_out.wdata = {{(DW-1){1'b0}}, slt};
      end
      LW: begin
        ex_out.wreg = 1'b1;
        ex_out.mem_addr = addr;
      end
      SW: ex_out.mem_addr = addr;
      MULT: begin
        ex_out.whilo = 1'b1;
        ex_out.hi = prod_q[2*DW-1:DW];
        ex_out.lo = prod_q[DW-1:0];
      end
      MFHI: begin
        ex_out.wreg = 1'b1;
        ex_out.wdata = hi_src;
      end
      MFLO: begin
        ex_out.wreg = 1'b1;
        ex_out.wdata = lo_src;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mem_stage import mips_pipe_pkg::*; import mips_except_pkg::*; (
  input  wire          clk,
  input  wire          reset,
  input  wire ex_mem_t mem_in,
  output logic         wb_valid,
  output wb_t          wb,
  output hilo_t        hilo,
  output logic         except_valid,
  output except_t      except_info
);

  localparam int DEPTH = `MIPS_MEM_WORDS;

  mem_addr_u addr;
  logic [`MIPS_DATA_W-1:0] mem [DEPTH];
  logic [`MIPS_DATA_W-1:0] load_data;
  logic misaligned;
  logic addr_fault;
  logic fault;
  except_code_e code;

  assign addr = mem_in.mem_addr;
  assign misaligned = (addr.fields.byte_off != 2'b00);
  assign load_data = mem[addr.fields.word_idx];

  // An overflow flagged in EX takes precedence over the address check.
  always_comb begin
    code = mem_in.except;
    if (code == NONE) begin
      if (mem_in.aluop == LW && misaligned) code = ADDR_LOAD;
      else if (mem_in.aluop == SW && misaligned) code = ADDR_STORE;
    end
  end

  assign fault = (code != NONE);
  assign addr_fault = (code == ADDR_LOAD) || (code == ADDR_STORE);
  assign except_valid = fault;

  always_comb begin
    except_info.code = code;
    except_info.pc = mem_in.pc;
    except_info.bad_addr = addr_fault ? addr.byte_addr : '0;
  end

  // ========================================
  // Data memory
  // ========================================

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (mem_in.aluop == SW && !fault) begin
      mem[addr.fields.word_idx] <= mem_in.reg2;
    end
  end

  // ========================================
  // Writeback and HI/LO
  // ========================================

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
      hilo <= '0;
    end else begin
      wb_valid <= mem_in.wreg && !fault;
      if (mem_in.whilo && !fault) begin
        hilo.hi <= mem_in.hi;
        hilo.lo <= mem_in.lo;
      end
    end
  end

  always_ff @(posedge clk) begin
    wb.wd <= mem_in.wd;
    wb.wdata <= (mem_in.aluop == LW) ? load_data : mem_in.wdata;
  end

endmodule

`default_nettype wire

/* verilog/mips_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_backend import mips_pipe_pkg::*; import mips_except_pkg::*; (
  input  wire         clk,
  input  wire         reset,
  input  wire         issue_valid,
  input  wire issue_t issue,
  output logic        issue_ready,
  input  wire         resume,
  output logic        wb_valid,
  output wb_t         wb,
  output logic        except_valid,
  output except_t     except_info
);

  ex_mem_t ex_out;
  ex_mem_t mem_in;
  hilo_t hilo;
  logic is_multi;
  logic en;
  logic flush;
  logic mult_start;
  logic timer_start;
  logic timer_done;

  ex_stage ex_stage0 (
    .clk(clk), .reset(reset), .issue(issue), .mult_start(mult_start),
    .hilo(hilo), .fwd(mem_in), .ex_out(ex_out), .is_multi(is_multi)
  );

  ex_mem ex_mem0 (
    .clk(clk), .reset(reset), .en(en), .flush(flush), .ex_in(ex_out), .mem_in(mem_in)
  );

  mem_stage mem_stage0 (
    .clk(clk), .reset(reset), .mem_in(mem_in), .wb_valid(wb_valid), .wb(wb),
    .hilo(hilo), .except_valid(except_valid), .except_info(except_info)
  );

  pipe_ctrl pipe_ctrl0 (
    .clk(clk), .reset(reset), .issue_valid(issue_valid), .is_multi(is_multi),
    .timer_done(timer_done), .except_valid(except_valid), .resume(resume),
    .issue_ready(issue_ready), .en(en), .flush(flush), .mult_start(mult_start),
    .timer_start(timer_start)
  );

  mult_timer mult_timer0 (
    .clk(clk), .reset(reset), .start(timer_start), .done(timer_done)
  );

endmodule

`default_nettype wire

/* verilog/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// ========================================
// Datapath sizes
// ========================================

`define MIPS_DATA_W 32
`define MIPS_REG_AW 5

// ========================================
// Memory and multiplier
// ========================================

`define MIPS_MEM_WORDS 64
`define MIPS_MULT_CYCLES 4 // Cycles that issue is held for a MULT.

`endif

/* verilog/mips_except_pkg.sv */
`default_nettype none

`include "mips_config.svh"

package mips_except_pkg;

  typedef enum logic [1:0] {
    NONE,
    OVERFLOW,
    ADDR_LOAD,
    ADDR_STORE
  } except_code_e;

  typedef struct packed {
    except_code_e            code;
    logic [`MIPS_DATA_W-1:0] pc;
    logic [`MIPS_DATA_W-1:0] bad_addr; // Zero unless the fault is an address fault.
  } except_t;

endpackage

`default_nettype wire

/* verilog/mips_pipe_pkg.sv */
`default_nettype none

`include "mips_config.svh"

package mips_pipe_pkg;
  import mips_except_pkg::*;

  localparam int WORD_IDX_W = $clog2(`MIPS_MEM_WORDS);
  localparam int UPPER_W = `MIPS_DATA_W - WORD_IDX_W - 2;

  typedef enum logic [3:0] {
    NOP, ADD, SUB, AND, OR, XOR, SLT, LW, SW, MULT, MFHI, MFLO
  } alu_op_e;

  // ========================================
  // Stage payloads
  // ========================================

  typedef struct packed {
    alu_op_e                 op;
    logic [`MIPS_DATA_W-1:0] pc;
    logic [`MIPS_DATA_W-1:0] rs_val;
    logic [`MIPS_DATA_W-1:0] rt_val;
    logic [`MIPS_DATA_W-1:0] imm; // Already sign extended.
    logic [`MIPS_REG_AW-1:0] wd;
  } issue_t;

  typedef struct packed {
    logic [`MIPS_REG_AW-1:0] wd;
    logic                    wreg;
    logic [`MIPS_DATA_W-1:0] wdata;
    logic [`MIPS_DATA_W-1:0] pc;
    logic                    whilo;
    logic [`MIPS_DATA_W-1:0] hi;
    logic [`MIPS_DATA_W-1:0] lo;
    alu_op_e                 aluop;
    logic [`MIPS_DATA_W-1:0] mem_addr;
    logic [`MIPS_DATA_W-1:0] reg2;
    except_code_e            except;
  } ex_mem_t;

  typedef struct packed {
    logic [UPPER_W-1:0]    upper;
    logic [WORD_IDX_W-1:0] word_idx;
    logic [1:0]            byte_off;
  } mem_addr_fields_t;

  typedef union packed {
    logic [`MIPS_DATA_W-1:0] byte_addr;
    mem_addr_fields_t        fields;
  } mem_addr_u;

  typedef struct packed {
    logic [`MIPS_REG_AW-1:0] wd;
    logic [`MIPS_DATA_W-1:0] wdata;
  } wb_t;

  typedef struct packed {
    logic [`MIPS_DATA_W-1:0] hi;
    logic [`MIPS_DATA_W-1:0] lo;
  } hilo_t;

endpackage

`default_nettype wire

/* verilog/mult_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mult_timer (
  input  wire  clk,
  input  wire  reset,
  input  wire  start,
  output logic done
);

  localparam int CNT_W = $clog2(`MIPS_MULT_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;
  logic busy_q;

  assign done = busy_q && (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
      cnt_q <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      cnt_q <= CNT_W'(`MIPS_MULT_CYCLES - 1); // The start edge counts as the first cycle.
    end else if (done) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
  input  wire  clk,
  input  wire  reset,
  input  wire  issue_valid,
  input  wire  is_multi,
  input  wire  timer_done,
  input  wire  except_valid,
  input  wire  resume,
  output logic issue_ready,
  output logic en,
  output logic flush,
  output logic mult_start,
  output logic timer_start
);

  typedef enum logic [1:0] {
    RUN,
    MULT_WAIT,
    HALT
  } state_e;

  state_e state_q;
  state_e state_d;
  logic live_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= RUN;
      live_q <= 1'b0; // Holds issue off for the first cycle out of reset.
    end else begin
      state_q <= state_d;
      live_q <= 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    issue_ready = 1'b0;
    mult_start = 1'b0;
    timer_start = 1'b0;
    case (state_q)
      RUN: begin
        if (except_valid) begin
          state_d = HALT;
        end else if (live_q && issue_valid && is_multi) begin
          mult_start = 1'b1;
          timer_start = 1'b1;
          state_d = MULT_WAIT;
        end else begin
          issue_ready = live_q;
        end
      end
      MULT_WAIT: begin
        if (timer_done) begin
          issue_ready = 1'b1; // The MULT completes its handshake here.
          state_d = RUN;
        end
      end
      HALT: if (resume) state_d = RUN;
      default: state_d = RUN;
    endcase
    en = issue_valid && issue_ready;
    flush = except_valid || (live_q && !en); // A cycle without an accept loads a bubble.
  end

endmodule

`default_nettype wire
